/* verilog/wb_params.svh */
// weight path sizing: lane and word widths, credit depths, read latency
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// ********************************************************************
// data widths
// ********************************************************************
// one read lane
`define WB_RD_WIDTH        16
// one memory word, four lanes
`define WB_WR_WIDTH        64

// ********************************************************************
// addressing
// ********************************************************************
// lane address, 128 lanes
`define WB_RD_ADDR_WIDTH   7
// word address, 32 words
`define WB_WR_ADDR_WIDTH   5
// low lane address bits pick the lane
`define WB_LANE_SEL_WIDTH  2

// ********************************************************************
// flow control and timing
// ********************************************************************
// loader queue depth, also the sender's starting credits
`define WB_LOAD_CREDITS    4
// consumer credits held by the fetch unit after reset
`define WB_OUT_CREDITS     4
// read_req to read_data, in cycles
`define WB_READ_LATENCY    3
// word and element counts
`define WB_COUNT_WIDTH     8
// stride field of a fetch command
`define WB_STRIDE_WIDTH    4

`endif

/* verilog/wb_pkg.sv */
// shared types of the weight path: load beats, fetch commands, output weights, fsm states
`include "wb_params.svh"

package wb_pkg;

  // ******************************************************************
  // load stream
  // ******************************************************************
  typedef enum logic [0:0] {
    LOAD_HDR  = 1'b0,
    LOAD_DATA = 1'b1
  } load_kind_e;

  // header beat or one weight word
  typedef struct packed {
    load_kind_e                 kind;
    logic [`WB_WR_WIDTH-1:0]    payload;
  } load_beat_t;

  // header view of the payload
  // base word address in the lowest bits, word count just above
  typedef struct packed {
    logic [`WB_WR_WIDTH-`WB_COUNT_WIDTH-`WB_WR_ADDR_WIDTH-1:0] reserved;
    logic [`WB_COUNT_WIDTH-1:0]                                  count;
    logic [`WB_WR_ADDR_WIDTH-1:0]                                base;
  } load_hdr_t;

  // ******************************************************************
  // fetch commands
  // ******************************************************************
  typedef enum logic [0:0] {
    FETCH_SEQ    = 1'b0,
    FETCH_STRIDE = 1'b1
  } fetch_op_e;

  // stride only matters for FETCH_STRIDE
  typedef struct packed {
    fetch_op_e                     op;
    logic [`WB_RD_ADDR_WIDTH-1:0]  base;
    logic [`WB_COUNT_WIDTH-1:0]    count;
    logic [`WB_STRIDE_WIDTH-1:0]   stride;
  } fetch_cmd_t;

  // ******************************************************************
  // output stream
  // ******************************************************************
  typedef struct packed {
    logic [`WB_RD_WIDTH-1:0]  data;
    logic                     last;
  } weight_out_t;

  // ******************************************************************
  // fsm states
  // ******************************************************************
  typedef enum logic [0:0] {
    LD_IDLE = 1'b0,
    LD_DATA = 1'b1
  } loader_state_e;

  typedef enum logic [0:0] {
    FT_IDLE  = 1'b0,
    FT_ISSUE = 1'b1
  } fetch_state_e;

endpackage

/* verilog/weight_buffer.sv */
// weight buffer: 64-bit word writes, 16-bit lane reads through a three-stage pipeline
`timescale 1ns/1ps
`include "wb_params.svh"

module weight_buffer
(
  input  logic                            clk,
  input  logic                            reset,

  input  logic                            read_req,
  input  logic [`WB_RD_ADDR_WIDTH-1:0]    read_addr,
  output logic [`WB_RD_WIDTH-1:0]         read_data,

  input  logic                            write_req,
  input  logic [`WB_WR_ADDR_WIDTH-1:0]    write_addr,
  input  logic [`WB_WR_WIDTH-1:0]         write_data
);

  // ******************************************************************
  // storage and pipeline registers
  // ******************************************************************
  localparam int NUM_WORDS = 1 << `WB_WR_ADDR_WIDTH;

  logic [`WB_WR_WIDTH-1:0]       mem [NUM_WORDS];

  // stage 1, split read address
  logic [`WB_WR_ADDR_WIDTH-1:0]  word_q;
  logic [`WB_LANE_SEL_WIDTH-1:0] lane_q;
  // stage 2, full word plus its lane select
  logic [`WB_WR_WIDTH-1:0]       word_data;
  logic [`WB_LANE_SEL_WIDTH-1:0] lane_qq;

  // request delayed to enable stages 2 and 3
  logic                          req_q;
  logic                          req_qq;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      req_q  <= 1'b0;
      req_qq <= 1'b0;
    end
    else
    begin
      req_q  <= read_req;
      req_qq <= req_q;
    end
  end

  // ******************************************************************
  // read path
  // ******************************************************************
  // upper bits address the word, lower bits the lane
  always_ff @(posedge clk)
  begin
    if (read_req)
      {word_q, lane_q} <= read_addr;
  end

  // word read, lane select rides along one stage
  always_ff @(posedge clk)
  begin
    if (req_q)
    begin
      word_data <= mem[word_q];
      lane_qq   <= lane_q;
    end
  end

  // lane mux, lane 0 is the low 16 bits
  always_ff @(posedge clk)
  begin
    if (req_qq)
      read_data <= word_data[lane_qq*`WB_RD_WIDTH +: `WB_RD_WIDTH];
  end

  // ******************************************************************
  // write path
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (write_req)
      mem[write_addr] <= write_data;
  end

  // a live request must carry a defined address
  a_read_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    read_req |-> !$isunknown(read_addr)
  );

endmodule

/* verilog/weight_loader.sv */
// weight loader turning credited header and data beats into sequential buffer writes
`timescale 1ns/1ps
`include "wb_params.svh"

module weight_loader
  import wb_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          load_valid,
  input  load_beat_t                    load_beat,
  output logic                          load_credit,

  output logic                          write_req,
  output logic [`WB_WR_ADDR_WIDTH-1:0]  write_addr,
  output logic [`WB_WR_WIDTH-1:0]       write_data,
  output logic                          load_done
);

  // ******************************************************************
  // beat queue
  // ******************************************************************
  localparam int DEPTH      = `WB_LOAD_CREDITS;
  localparam int PTR_WIDTH  = $clog2(DEPTH);
  localparam int FILL_WIDTH = PTR_WIDTH + 1;

  load_beat_t                    queue [DEPTH];
  logic [PTR_WIDTH-1:0]          wr_ptr;
  logic [PTR_WIDTH-1:0]          rd_ptr;
  logic [FILL_WIDTH-1:0]         fill;
  logic                          pop;
  load_beat_t                    head;
  load_hdr_t                     hdr;

  // write sequencer
  loader_state_e                 state;
  logic [`WB_WR_ADDR_WIDTH-1:0]  cur_addr;
  logic [`WB_COUNT_WIDTH-1:0]    words_left;
  logic                          data_pop;
  // data beats that arrived with no header open
  logic [`WB_COUNT_WIDTH-1:0]    dropped;

  // one beat leaves per cycle while any is queued
  assign pop      = (fill != '0);
  assign head     = queue[rd_ptr];
  assign hdr      = head.payload;
  assign data_pop = pop && (head.kind == LOAD_DATA);

  // beat storage
  always_ff @(posedge clk)
  begin
    if (load_valid)
      queue[wr_ptr] <= load_beat;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (load_valid)
        wr_ptr <= wr_ptr + PTR_WIDTH'(1);
      if (pop)
        rd_ptr <= rd_ptr + PTR_WIDTH'(1);
      fill <= fill + FILL_WIDTH'(load_valid) - FILL_WIDTH'(pop);
    end
  end

  // ******************************************************************
  // header decode and word writes
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= LD_IDLE;
      cur_addr    <= '0;
      words_left  <= '0;
      dropped     <= '0;
      load_credit <= 1'b0;
      write_req   <= 1'b0;
      load_done   <= 1'b0;
    end
    else
    begin
      // every popped beat frees a sender credit
      load_credit <= pop;
      write_req   <= 1'b0;
      load_done   <= 1'b0;
      if (pop && (head.kind == LOAD_HDR))
      begin
        cur_addr   <= hdr.base;
        words_left <= hdr.count;
        state      <= (hdr.count != '0) ? LD_DATA : LD_IDLE;
      end
      else if (data_pop && (state == LD_DATA))
      begin
        write_req  <= 1'b1;
        // 5-bit add wraps past word 31
        cur_addr   <= cur_addr + `WB_WR_ADDR_WIDTH'(1);
        words_left <= words_left - `WB_COUNT_WIDTH'(1);
        if (words_left == `WB_COUNT_WIDTH'(1))
        begin
          state     <= LD_IDLE;
          load_done <= 1'b1;
        end
      end
      else if (data_pop)
        dropped <= dropped + `WB_COUNT_WIDTH'(1);
    end
  end

  // address and word of the popped data beat
  always_ff @(posedge clk)
  begin
    if (data_pop)
    begin
      write_addr <= cur_addr;
      write_data <= head.payload;
    end
  end

  // sender stays within its credits
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    load_valid |-> (fill != FILL_WIDTH'(DEPTH))
  );

  // every data beat follows a header
  a_no_dropped_data: assert property (
    @(posedge clk) disable iff (reset)
    dropped == '0
  );

endmodule

/* verilog/weight_fetch.sv */
// weight fetch sequencer issuing strided buffer reads under output credits
`timescale 1ns/1ps
`include "wb_params.svh"

module weight_fetch
  import wb_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          cmd_valid,
  input  fetch_cmd_t                    cmd,
  output logic                          cmd_ready,

  output logic                          read_req,
  output logic [`WB_RD_ADDR_WIDTH-1:0]  read_addr,
  input  logic [`WB_RD_WIDTH-1:0]       read_data,

  output logic                          out_valid,
  output weight_out_t                   out_weight,
  input  logic                          out_credit
);

  // ******************************************************************
  // sequencer state
  // ******************************************************************
  localparam int CRED_WIDTH = $clog2(`WB_OUT_CREDITS + 1);
  localparam int LAT        = `WB_READ_LATENCY;

  fetch_state_e                   state;
  logic [CRED_WIDTH-1:0]          credits;
  logic [`WB_RD_ADDR_WIDTH-1:0]   cur_addr;
  logic [`WB_RD_ADDR_WIDTH-1:0]   step;
  logic [`WB_COUNT_WIDTH-1:0]     elems_left;
  logic                           read_last;
  logic                           cmd_take;
  logic                           issue;

  // valid and last delayed to meet read_data
  logic [LAT-1:0]                 valid_pipe;
  logic [LAT-1:0]                 last_pipe;

  // the single command stage opens only between commands
  assign cmd_ready = (state == FT_IDLE);
  assign cmd_take  = cmd_valid && cmd_ready;

  // a credit returned this cycle can be spent right away
  assign issue = (state == FT_ISSUE) && ((credits != '0) || out_credit);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= FT_IDLE;
      credits    <= CRED_WIDTH'(`WB_OUT_CREDITS);
      cur_addr   <= '0;
      step       <= '0;
      elems_left <= '0;
      read_req   <= 1'b0;
    end
    else
    begin
      read_req <= issue;
      credits  <= credits + CRED_WIDTH'(out_credit) - CRED_WIDTH'(issue);

      if (cmd_take)
      begin
        cur_addr   <= cmd.base;
        elems_left <= cmd.count;
        // sequential fetch steps one lane
        if (cmd.op == FETCH_SEQ)
          step <= `WB_RD_ADDR_WIDTH'(1);
        else
          step <= `WB_RD_ADDR_WIDTH'(cmd.stride);
        // empty command completes on acceptance
        if (cmd.count != '0)
          state <= FT_ISSUE;
      end
      else if (issue)
      begin
        // 7-bit add wraps modulo 128
        cur_addr   <= cur_addr + step;
        elems_left <= elems_left - `WB_COUNT_WIDTH'(1);
        if (elems_left == `WB_COUNT_WIDTH'(1))
          state <= FT_IDLE;
      end
    end
  end

  // address and last flag of the issued read
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      read_addr <= cur_addr;
      read_last <= (elems_left == `WB_COUNT_WIDTH'(1));
    end
  end

  // ******************************************************************
  // output alignment
  // ******************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
      valid_pipe <= '0;
    else
      valid_pipe <= {valid_pipe[LAT-2:0], read_req};
  end

  // last flag travels alongside valid
  always_ff @(posedge clk)
  begin
    last_pipe <= {last_pipe[LAT-2:0], read_req && read_last};
  end

  assign out_valid  = valid_pipe[LAT-1];
  assign out_weight = '{data: read_data, last: last_pipe[LAT-1]};

  // consumer returns no more credits than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (reset)
    credits <= CRED_WIDTH'(`WB_OUT_CREDITS)
  );

endmodule

/* verilog/weight_subsystem.sv */
// weight storage path: loader writes the buffer, fetch sequencer streams it out
`timescale 1ns/1ps
`include "wb_params.svh"

module weight_subsystem
  import wb_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // load stream, credit based
  input  logic         load_valid,
  input  load_beat_t   load_beat,
  output logic         load_credit,
  output logic         load_done,

  // fetch commands, valid/ready
  input  logic         cmd_valid,
  input  fetch_cmd_t   cmd,
  output logic         cmd_ready,

  // weight stream to the pe array, credit based
  output logic         out_valid,
  output weight_out_t  out_weight,
  input  logic         out_credit
);

  // ******************************************************************
  // buffer ports
  // ******************************************************************
  logic                          write_req;
  logic [`WB_WR_ADDR_WIDTH-1:0]  write_addr;
  logic [`WB_WR_WIDTH-1:0]       write_data;

  logic                          read_req;
  logic [`WB_RD_ADDR_WIDTH-1:0]  read_addr;
  logic [`WB_RD_WIDTH-1:0]       read_data;

  // ******************************************************************
  // instances
  // ******************************************************************
  weight_loader i_weight_loader (
    .clk         (clk),
    .reset       (reset),
    .load_valid  (load_valid),
    .load_beat   (load_beat),
    .load_credit (load_credit),
    .write_req   (write_req),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .load_done   (load_done)
  );

  // write and read ports are independent
  weight_buffer i_weight_buffer (
    .clk        (clk),
    .reset      (reset),
    .read_req   (read_req),
    .read_addr  (read_addr),
    .read_data  (read_data),
    .write_req  (write_req),
    .write_addr (write_addr),
    .write_data (write_data)
  );

  weight_fetch i_weight_fetch (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .read_req   (read_req),
    .read_addr  (read_addr),
    .read_data  (read_data),
    .out_valid  (out_valid),
    .out_weight (out_weight),
    .out_credit (out_credit)
  );

endmodule

/* bench/tb_clock.sv */
// testbench clock source, free running from time zero
`timescale 1ns/1ps

module tb_clock
#(
  // full period in ns
  parameter int PERIOD = 8
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* bench/weight_subsystem_tb.sv */
// weight subsystem testbench that loads random weights and checks every fetched lane
`timescale 1ns/1ps
`include "wb_params.svh"

module weight_subsystem_tb
  import wb_pkg::*;
();

  localparam int TIMEOUT   = 2000;
  localparam int NUM_WORDS = 1 << `WB_WR_ADDR_WIDTH;

  logic         clk;
  logic         reset      = 1'b1;
  logic         load_valid = 1'b0;
  load_beat_t   load_beat  = '0;
  logic         cmd_valid  = 1'b0;
  fetch_cmd_t   cmd        = '0;
  logic         out_credit = 1'b0;
  logic         load_credit;
  logic         load_done;
  logic         cmd_ready;
  logic         out_valid;
  weight_out_t  out_weight;

  integer       seed = 32'h2749;
  int           data_errors = 0;
  int           credit_errors = 0;
  int           flow_errors = 0;
  // sender side load credits and pulse counters
  int           load_cred = `WB_LOAD_CREDITS;
  int           credit_pulses = 0;
  int           done_pulses = 0;
  // consumer side weights not yet credited back
  int           held_cnt = 0;
  logic         bp_mode = 1'b0;
  logic         hold_credit = 1'b0;
  int           stretch = 0;

  logic [`WB_WR_WIDTH-1:0]  model_mem [NUM_WORDS];
  weight_out_t              exp_q [$];

  tb_clock #(.PERIOD(8)) i_tb_clock (.clk(clk));

  weight_subsystem i_weight_subsystem (
    .clk         (clk),
    .reset       (reset),
    .load_valid  (load_valid),
    .load_beat   (load_beat),
    .load_credit (load_credit),
    .load_done   (load_done),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .out_valid   (out_valid),
    .out_weight  (out_weight),
    .out_credit  (out_credit)
  );

  // *******************************************************************
  // reference model
  // *******************************************************************
  // upper lane bits pick the word and lane 0 is the low 16 bits
  function automatic logic [`WB_RD_WIDTH-1:0] expected_weight(input logic [6:0] lane_addr);
    logic [`WB_WR_ADDR_WIDTH-1:0]  word;
    logic [`WB_LANE_SEL_WIDTH-1:0] lane;
    word = lane_addr[6:2];
    lane = lane_addr[1:0];
    return model_mem[word][lane*`WB_RD_WIDTH +: `WB_RD_WIDTH];
  endfunction

  // one entry per element stepping by 1 or the stride modulo 128
  task automatic expect_fetch(input fetch_cmd_t c);
    logic [`WB_RD_ADDR_WIDTH-1:0] addr;
    logic [`WB_RD_ADDR_WIDTH-1:0] step;
    weight_out_t                  w;
    addr = c.base;
    step = (c.op == FETCH_SEQ) ? 7'd1 : 7'(c.stride);
    for (int i = 0; i < int'(c.count); i++)
    begin
      w.data = expected_weight(addr);
      w.last = (i == int'(c.count) - 1);
      exp_q.push_back(w);
      addr = addr + step;
    end
  endtask

  // *******************************************************************
  // flow control processes
  // *******************************************************************
  // sender credits come back on load_credit and go out with each beat
  always @(posedge clk)
  begin
    if (reset)
      load_cred <= `WB_LOAD_CREDITS;
    else
    begin
      load_cred <= load_cred + int'(load_credit) - int'(load_valid);
      if (load_credit)
        credit_pulses <= credit_pulses + 1;
      if (load_done)
        done_pulses <= done_pulses + 1;
    end
  end

  // random hold stretches while back-pressure is on
  always @(posedge clk)
  begin
    if (!bp_mode)
    begin
      hold_credit <= 1'b0;
      stretch     <= 0;
    end
    else if (stretch == 0)
    begin
      hold_credit <= ~hold_credit;
      stretch     <= $random(seed) & 15;
    end
    else
      stretch <= stretch - 1;
  end

  // consumer frees one weight per cycle unless holding
  always @(posedge clk)
  begin
    int   held;
    logic give;
    if (reset)
    begin
      held_cnt   <= 0;
      out_credit <= 1'b0;
    end
    else
    begin
      held = held_cnt + int'(out_valid);
      if (held > `WB_OUT_CREDITS)
      begin
        $display("ERROR %0t: %0d weights held, only %0d credits granted",
                 $time, held, `WB_OUT_CREDITS);
        credit_errors++;
      end
      give = (held > 0) && !hold_credit;
      out_credit <= give;
      held_cnt   <= held - int'(give);
    end
  end

  // *******************************************************************
  // output checker
  // *******************************************************************
  always @(posedge clk)
  begin
    weight_out_t exp;
    if (!reset && out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("ERROR %0t: unexpected weight %h", $time, out_weight.data);
        data_errors++;
      end
      else
      begin
        exp = exp_q.pop_front();
        if (out_weight.data !== exp.data || out_weight.last !== exp.last)
        begin
          $display("ERROR %0t: got data %h last %b, expected data %h last %b", $time,
                   out_weight.data, out_weight.last, exp.data, exp.last);
          data_errors++;
        end
      end
    end
  end

  // *******************************************************************
  // stimulus tasks
  // *******************************************************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("errors: %0d data, %0d credit, %0d flow", data_errors, credit_errors,
             flow_errors);
    $display("Something failed");
    $finish;
  endtask

  // called at a rising edge and returns at the accepting edge
  task automatic send_beat(input load_beat_t beat);
    int waited;
    waited = 0;
    while (load_cred - int'(load_valid) <= 0)
    begin
      load_valid <= 1'b0;
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for a load credit");
    end
    load_valid <= 1'b1;
    load_beat  <= beat;
    @(posedge clk);
  endtask

  // header beat and random words followed by a count of the returned pulses
  task automatic load_words(input int base, input int count);
    load_hdr_t  hdr;
    load_beat_t beat;
    int         credits_before;
    int         done_before;
    int         waited;
    credits_before = credit_pulses;
    done_before    = done_pulses;
    hdr            = '0;
    hdr.base       = `WB_WR_ADDR_WIDTH'(base);
    hdr.count      = `WB_COUNT_WIDTH'(count);
    beat.kind      = LOAD_HDR;
    beat.payload   = hdr;
    send_beat(beat);
    for (int i = 0; i < count; i++)
    begin
      beat.kind    = LOAD_DATA;
      beat.payload = {$random(seed), $random(seed)};
      model_mem[`WB_WR_ADDR_WIDTH'(base + i)] = beat.payload;
      send_beat(beat);
    end
    load_valid <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for load credits to return");
    end
    while (load_cred != `WB_LOAD_CREDITS);
    repeat (2) @(posedge clk);
    // one credit per beat including the header
    if (credit_pulses - credits_before != count + 1)
    begin
      $display("ERROR %0t: %0d load credits returned, expected %0d", $time,
               credit_pulses - credits_before, count + 1);
      flow_errors++;
    end
    if (done_pulses - done_before != 1)
    begin
      $display("ERROR %0t: %0d load_done pulses, expected 1", $time, done_pulses - done_before);
      flow_errors++;
    end
  endtask

  // expected stream goes in before cmd_valid is held until acceptance
  task automatic run_fetch(input fetch_cmd_t c);
    int waited;
    expect_fetch(c);
    cmd_valid <= 1'b1;
    cmd       <= c;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run("fetch command was never accepted");
    end
    while (!cmd_ready);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || !cmd_ready)
    begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for the weight stream to drain");
    end
    repeat (6) @(posedge clk);
  endtask

  function automatic fetch_cmd_t make_cmd(input fetch_op_e op, input int base,
                                          input int count, input int stride);
    fetch_cmd_t c;
    c.op     = op;
    c.base   = `WB_RD_ADDR_WIDTH'(base);
    c.count  = `WB_COUNT_WIDTH'(count);
    c.stride = `WB_STRIDE_WIDTH'(stride);
    return c;
  endfunction

  function automatic fetch_cmd_t random_stride_cmd();
    return make_cmd(FETCH_STRIDE, $random(seed) & 127, 1 + ($random(seed) & 63),
                    $random(seed) & 15);
  endfunction

  // *******************************************************************
  // test sequence
  // *******************************************************************
  initial
  begin
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle outputs right after reset
    repeat (4)
    begin
      @(posedge clk);
      if (out_valid || load_credit || load_done || !cmd_ready)
      begin
        $display("ERROR %0t: outputs not idle after reset", $time);
        flow_errors++;
      end
    end
    // full load and the whole buffer read back in lane order
    load_words(0, NUM_WORDS);
    run_fetch(make_cmd(FETCH_SEQ, 0, 128, 0));
    wait_drain();
    // strided fetches starting with a forced wrap past lane 127
    run_fetch(make_cmd(FETCH_STRIDE, 120, 10, 5));
    wait_drain();
    repeat (4)
    begin
      run_fetch(random_stride_cmd());
      wait_drain();
    end
    // consumer holds credits in random stretches
    bp_mode <= 1'b1;
    repeat (3)
    begin
      run_fetch(random_stride_cmd());
      wait_drain();
    end
    bp_mode <= 1'b0;
    // words 9 to 11 rewritten and words 7 to 13 read back
    load_words(9, 3);
    run_fetch(make_cmd(FETCH_SEQ, 28, 28, 0));
    wait_drain();
    // second command queued behind the first
    run_fetch(random_stride_cmd());
    run_fetch(make_cmd(FETCH_SEQ, $random(seed) & 127, 1 + ($random(seed) & 31), 0));
    wait_drain();
    $display("errors: %0d data, %0d credit, %0d flow", data_errors, credit_errors,
             flow_errors);
    if (data_errors == 0 && credit_errors == 0 && flow_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/weight_buffer.sv
verilog/weight_loader.sv
verilog/weight_fetch.sv
verilog/weight_subsystem.sv
bench/tb_clock.sv
bench/weight_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the weight subsystem testbench.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module weight_subsystem_tb \
  -o weight_subsystem_sim &&
./obj_dir/weight_subsystem_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Everything OK" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
